// File: verif/hwpe_patterns.txt
// first word: number of jobs; then per job: mode len core_id flags, A words, B words, expected
// flags bit0 random grant stalls, bit1 gate closed mid-job, bit2 test mode with enable low,
// bit3 configuration write while busy; mode 0 is one 32-bit value, mode 1 two 16-bit lanes
00000008

// word mode with a negative operand, 15 - 8 + 42
0 3 2 0  00000003 FFFFFFFE 00000007  00000005 00000004 00000006  00000031

// empty job writes zero
0 0 5 0  00000000

// product of 2^16 by 2^16 wraps to zero, stalls on the grant
0 2 0 1  00010000 FFFFFFFF  00010000 00000003  FFFFFFFD

// lane mode with sign extension of both halves, -7 + 98302
1 2 7 0  0002FFFD FFFF7FFF  00040005 80000002  00017FF7

// lane mode with stalls and the gate closed for a while, 39 - 22 + 131072
1 3 1 3  00030004 FFFEFFFF 01000100  00050006 00070008 01000100  00020011

// word mode while a configuration write is refused, -256 - 65536
0 2 4 8  FFFFFFF0 00000100  00000010 FFFFFF00  FFFEFF00

// test mode runs the engine with the enable low
0 4 3 4  00000001 00000002 00000003 00000004  0000000A 00000014 0000001E 00000028  0000012C

// lane extremes, the sum wraps past 2^32
1 4 6 1  7FFF7FFF 80008000 0001FFFF 00000000  7FFF7FFF 80008000 FFFF0001 12345678  FFFE0000

// File: compile.f
verilog/hwpe_pkg.sv
verilog/hwpe_clock_gate.sv
verilog/hwpe_ctrl_regs.sv
verilog/hwpe_dot_engine.sv
verilog/hwpe_subsystem.sv
verif/tb_clk_gen.sv
verif/tb_hwpe_subsystem.sv

// File: Makefile
SIM  = obj_dir/Vtb_hwpe_subsystem
SRCS = $(shell cat compile.f)

.PHONY: all run clean

all: $(SIM)

# relinked only when a source or the file list is newer than the binary
$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module tb_hwpe_subsystem -f compile.f

# the binary exits with a failing status when the testbench stops on $fatal
run: $(SIM) verif/hwpe_patterns.txt
	./$(SIM)

clean:
	rm -rf obj_dir

// File: verif/tb_hwpe_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hwpe_subsystem;

  import hwpe_pkg::*;

  localparam int N_CORES   = 8;
  localparam int PAT_WORDS = 256;
  localparam int MEM_WORDS = 4096;

  logic                    clk;
  logic                    rst_n;
  logic                    test_mode;
  logic                    hwpe_en;
  apb_req_t                apb_req;
  apb_rsp_t                apb_rsp;
  mem_req_t                mem_req;
  mem_rsp_t                mem_rsp = '0;
  logic [N_CORES-1:0][1:0] evt;
  logic                    busy;

  logic [31:0] pat [0:PAT_WORDS-1];
  logic [31:0] mem [0:MEM_WORDS-1];
  // request as seen mid-cycle, which cannot change before the next rising edge
  mem_req_t    req_snap    = '0;
  logic        rd_pend     = 1'b0;
  logic [11:0] rd_idx      = '0;
  logic        stall_en    = 1'b0;
  int          wr_count    = 0;
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;

  tb_clk_gen #(
    .PERIOD_NS ( 100 )
  ) i_clk_gen (
    .clk_o ( clk )
  );

  hwpe_subsystem #(
    .N_CORES ( N_CORES )
  ) UUT (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .test_mode_i ( test_mode ),
    .hwpe_en_i   ( hwpe_en   ),
    .apb_i       ( apb_req   ),
    .apb_o       ( apb_rsp   ),
    .mem_req_o   ( mem_req   ),
    .mem_rsp_i   ( mem_rsp   ),
    .evt_o       ( evt       ),
    .busy_o      ( busy      )
  );

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // grant and read data are driven mid-cycle and stalls draw a coin per cycle
  always @(negedge clk)
  begin
    req_snap        = mem_req;
    mem_rsp.gnt     = mem_req.req && (!stall_en || ($urandom % 2 == 0));
    mem_rsp.r_valid = rd_pend;
    mem_rsp.r_data  = rd_pend ? mem[rd_idx] : 32'h0;
  end

  // a handshake only counts on an edge that also reaches the engine
  always @(posedge clk)
  begin
    rd_pend <= 1'b0;
    if (req_snap.req && mem_rsp.gnt && (hwpe_en || test_mode))
    begin
      if (req_snap.wen)
      begin
        rd_pend <= 1'b1;
        rd_idx  <= req_snap.add[13:2];
      end
      else
      begin
        mem[req_snap.add[13:2]] = req_snap.wdata;
        wr_count                <= wr_count + 1;
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
      abort_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
  end

  // one APB transfer that starts and ends on a falling edge
  task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic slverr);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    // response settles well inside the low phase of the access cycle
    #10;
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    assert (apb_rsp.pready === 1'b1)
    else abort_run($sformatf("FAIL %0t: pready low in the access cycle at 0x%02h",
                             $time, addr));
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, addr, data, rdata, err);
    assert (err === exp_err)
    else abort_run($sformatf("FAIL %0t: write to 0x%02h gave pslverr %b, expected %b",
                             $time, addr, err, exp_err));
  endtask

  task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, addr, 32'h0, rdata, err);
    assert (rdata === exp && err === 1'b0)
    else abort_run($sformatf("FAIL %0t: %s at 0x%02h read 0x%08h, expected 0x%08h",
                             $time, what, addr, rdata, exp));
  endtask

  // record layout is mode, len, core id, flags, A words, B words, expected sum
  task automatic run_job(input int job, input int base, output int next);
    logic [31:0]             mode;
    logic [15:0]             len;
    logic [7:0]              core;
    logic [3:0]              flags;
    logic [31:0]             a_addr;
    logic [31:0]             b_addr;
    logic [31:0]             c_addr;
    logic [31:0]             expected;
    logic [N_CORES-1:0][1:0] exp_evt;
    int                      wr_before;
    mem_req_t                req_gate;
    mode     = pat[base];
    len      = pat[base+1][15:0];
    core     = pat[base+2][7:0];
    flags    = pat[base+3][3:0];
    a_addr   = 32'h0000_0000 + job * 32'h40;
    b_addr   = 32'h0000_1000 + job * 32'h40;
    c_addr   = 32'h0000_2000 + job * 32'h4;
    expected = pat[base+4+2*len];
    next     = base + 5 + 2 * len;
    for (int i = 0; i < len; i++)
    begin
      mem[int'(a_addr[13:2]) + i] = pat[base+4+i];
      mem[int'(b_addr[13:2]) + i] = pat[base+4+len+i];
    end
    stall_en = flags[0];
    write_reg(REG_A_ADDR, a_addr, 1'b0);
    write_reg(REG_B_ADDR, b_addr, 1'b0);
    write_reg(REG_C_ADDR, c_addr, 1'b0);
    write_reg(REG_LEN, {16'h0, len}, 1'b0);
    write_reg(REG_MODE, mode, 1'b0);
    write_reg(REG_CORE_ID, {24'h0, core}, 1'b0);
    // test mode has to keep the gate open with the enable low
    if (flags[2])
    begin
      test_mode = 1'b1;
      hwpe_en   = 1'b0;
    end
    wr_before = wr_count;
    write_reg(REG_TRIGGER, 32'h1, 1'b0);
    assert (busy === 1'b1)
    else abort_run($sformatf("FAIL %0t: busy_o low after trigger of job %0d", $time, job));
    if (flags[3])
      write_reg(REG_A_ADDR, 32'hDEAD_BEE0, 1'b1);
    // the engine has taken start by now and holds no read in flight
    if (flags[1])
    begin
      @(negedge clk);
      hwpe_en  = 1'b0;
      req_gate = mem_req;
      repeat (20)
      begin
        @(negedge clk);
        assert (busy === 1'b1 && mem_req === req_gate)
        else abort_run($sformatf("FAIL %0t: job %0d moved while the gate was closed",
                                 $time, job));
      end
      hwpe_en = 1'b1;
    end
    exp_evt          = '0;
    exp_evt[core][0] = 1'b1;
    while (busy === 1'b1)
    begin
      assert (evt === '0)
      else abort_run($sformatf("FAIL %0t: event 0x%04h while job %0d ran", $time, evt, job));
      @(negedge clk);
    end
    // the done event must sit in the very cycle that busy drops
    assert (evt === exp_evt)
    else abort_run($sformatf("FAIL %0t: event 0x%04h at end of job %0d, expected 0x%04h",
                             $time, evt, job, exp_evt));
    @(negedge clk);
    assert (evt === '0)
    else abort_run($sformatf("FAIL %0t: event of job %0d longer than a cycle", $time, job));
    test_mode = 1'b0;
    hwpe_en   = 1'b1;
    stall_en  = 1'b0;
    assert (mem[c_addr[13:2]] === expected)
    else abort_run($sformatf("FAIL %0t: job %0d stored 0x%08h, expected 0x%08h",
                             $time, job, mem[c_addr[13:2]], expected));
    assert (wr_count == wr_before + 1)
    else abort_run($sformatf("FAIL %0t: job %0d made %0d writes, expected one",
                             $time, job, wr_count - wr_before));
    check_reg(REG_RESULT, expected, "result register");
    check_reg(REG_STATUS, 32'h0, "status register");
    if (flags[3])
      check_reg(REG_A_ADDR, a_addr, "A address after a write while busy");
  endtask

  initial
  begin
    int n_jobs;
    int n_elems;
    int ptr;
    int next_ptr;
    rst_n     = 1'b0;
    test_mode = 1'b0;
    hwpe_en   = 1'b1;
    apb_req   = '0;
    void'($urandom(32'h97da));
    // fill words carry their own index so stale data never looks like a result
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = {4'hC, 12'(i), 4'h3, ~12'(i)};
    $readmemh("verif/hwpe_patterns.txt", pat);
    assert (!$isunknown(pat[0]))
    else abort_run("the pattern file verif/hwpe_patterns.txt could not be read");
    n_jobs  = pat[0];
    n_elems = 0;
    ptr     = 1;
    for (int j = 0; j < n_jobs; j++)
    begin
      n_elems += pat[ptr+1];
      ptr     += 5 + 2 * pat[ptr+1];
    end
    cycle_limit = 64 * n_elems + 200 * n_jobs;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    assert (busy === 1'b0 && evt === '0 && mem_req.req === 1'b0)
    else abort_run($sformatf("FAIL %0t: outputs not idle after reset", $time));
    for (int a = 4; a <= 32; a += 4)
      check_reg(8'(a), 32'h0, "register after reset");
    ptr = 1;
    for (int j = 0; j < n_jobs; j++)
    begin
      run_job(j, ptr, next_ptr);
      ptr = next_ptr;
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  // starts low so the first rising edge comes half a period in
  initial
  begin
    clk_o = 1'b0;
    forever
      #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: verilog/hwpe_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module hwpe_subsystem #(
  parameter int N_CORES = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    test_mode_i,
  input  logic                    hwpe_en_i,
  input  hwpe_pkg::apb_req_t      apb_i,
  output hwpe_pkg::apb_rsp_t      apb_o,
  output hwpe_pkg::mem_req_t      mem_req_o,
  input  hwpe_pkg::mem_rsp_t      mem_rsp_i,
  output logic [N_CORES-1:0][1:0] evt_o,
  output logic                    busy_o
);

  import hwpe_pkg::*;

  logic        hwpe_clk;
  job_cfg_t    job_cfg;
  logic        job_start;
  logic        job_done;
  logic [31:0] job_result;

  // the engine only resets while its clock gate is open
  hwpe_clock_gate i_hwpe_clock_gate (
    .clk_i     ( clk_i       ),
    .en_i      ( hwpe_en_i   ),
    .test_en_i ( test_mode_i ),
    .clk_o     ( hwpe_clk    )
  );

  // registers stay on the free clock so cores can always reach them
  hwpe_ctrl_regs #(
    .N_CORES ( N_CORES )
  ) i_ctrl_regs (
    .clk_i    ( clk_i      ),
    .rst_n_i  ( rst_n_i    ),
    .apb_i    ( apb_i      ),
    .apb_o    ( apb_o      ),
    .cfg_o    ( job_cfg    ),
    .start_o  ( job_start  ),
    .done_i   ( job_done   ),
    .result_i ( job_result ),
    .busy_o   ( busy_o     ),
    .evt_o    ( evt_o      )
  );

  hwpe_dot_engine i_dot_engine (
    .clk_i     ( hwpe_clk   ),
    .rst_n_i   ( rst_n_i    ),
    .cfg_i     ( job_cfg    ),
    .start_i   ( job_start  ),
    .done_o    ( job_done   ),
    .result_o  ( job_result ),
    .mem_req_o ( mem_req_o  ),
    .mem_rsp_i ( mem_rsp_i  )
  );

endmodule

`default_nettype wire

// File: verilog/hwpe_dot_engine.sv
`timescale 1ns/1ps
`default_nettype none

module hwpe_dot_engine (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  hwpe_pkg::job_cfg_t cfg_i,
  input  logic               start_i,
  output logic               done_o,
  output logic [31:0]        result_o,
  output hwpe_pkg::mem_req_t mem_req_o,
  input  hwpe_pkg::mem_rsp_t mem_rsp_i
);

  import hwpe_pkg::*;

  // at most one read is in flight so each fetch has its own wait state
  typedef enum logic [2:0] {
    S_IDLE,
    S_RD_A,
    S_WAIT_A,
    S_RD_B,
    S_WAIT_B,
    S_WRITE,
    S_DONE
  } state_e;

  state_e            state_q;
  job_cfg_t          cfg_q;
  logic [15:0]       idx_q;
  logic [31:0]       acc_q;
  operand_u          a_q;
  operand_u          rsp_op;
  logic [ADDR_W-1:0] elem_off;
  logic              last_elem;

  // product of one element pair that wraps modulo 2^32
  function automatic logic [31:0] mac_term(operand_u a, operand_u b, mode_e mode);
    logic signed [31:0] p_hi;
    logic signed [31:0] p_lo;
    if (mode == MODE_H16)
    begin
      // the lanes are sign extended to 32 bits before multiplying
      p_hi = a.h16.hi * b.h16.hi;
      p_lo = a.h16.lo * b.h16.lo;
      return p_hi + p_lo;
    end
    return a.w32 * b.w32;
  endfunction

  assign rsp_op    = mem_rsp_i.r_data;
  assign elem_off  = {{(ADDR_W-18){1'b0}}, idx_q, 2'b00};
  assign last_elem = (idx_q == cfg_q.len - 16'd1);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= S_IDLE;
    end
    else
    begin
      case (state_q)
        S_IDLE:
        begin
          // an empty job goes straight to writing the zero sum
          if (start_i)
            state_q <= (cfg_i.len == 16'd0) ? S_WRITE : S_RD_A;
        end
        S_RD_A:
        begin
          if (mem_rsp_i.gnt)
            state_q <= S_WAIT_A;
        end
        S_WAIT_A:
        begin
          if (mem_rsp_i.r_valid)
            state_q <= S_RD_B;
        end
        S_RD_B:
        begin
          if (mem_rsp_i.gnt)
            state_q <= S_WAIT_B;
        end
        S_WAIT_B:
        begin
          if (mem_rsp_i.r_valid)
            state_q <= last_elem ? S_WRITE : S_RD_A;
        end
        S_WRITE:
        begin
          if (mem_rsp_i.gnt)
            state_q <= S_DONE;
        end
        default:
        begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // the job is loaded on start and the sum grows with every B response
  always_ff @(posedge clk_i)
  begin
    if (state_q == S_IDLE && start_i)
    begin
      cfg_q <= cfg_i;
      idx_q <= '0;
      acc_q <= '0;
    end
    if (state_q == S_WAIT_A && mem_rsp_i.r_valid)
      a_q <= rsp_op;
    if (state_q == S_WAIT_B && mem_rsp_i.r_valid)
    begin
      acc_q <= acc_q + mac_term(a_q, rsp_op, cfg_q.mode);
      idx_q <= idx_q + 16'd1;
    end
  end

  // request fields depend only on registered state and hold until granted
  always_comb
  begin
    mem_req_o.req   = 1'b0;
    mem_req_o.wen   = 1'b1;
    mem_req_o.add   = '0;
    mem_req_o.wdata = '0;
    case (state_q)
      S_RD_A:
      begin
        mem_req_o.req = 1'b1;
        mem_req_o.add = cfg_q.a_addr + elem_off;
      end
      S_RD_B:
      begin
        mem_req_o.req = 1'b1;
        mem_req_o.add = cfg_q.b_addr + elem_off;
      end
      S_WRITE:
      begin
        mem_req_o.req   = 1'b1;
        mem_req_o.wen   = 1'b0;
        mem_req_o.add   = cfg_q.c_addr;
        mem_req_o.wdata = acc_q;
      end
      default: ;
    endcase
  end

  // the reported result is the word that was just stored
  assign done_o   = (state_q == S_DONE);
  assign result_o = acc_q;

  // a stalled request may not change under the memory
  req_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (mem_req_o.req && !mem_rsp_i.gnt) |=> $stable(mem_req_o)
  );

  // read data only comes back for a read that was granted
  rvalid_after_grant: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mem_rsp_i.r_valid |-> $past(mem_req_o.req && mem_req_o.wen && mem_rsp_i.gnt)
  );

endmodule

`default_nettype wire

// File: verilog/hwpe_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module hwpe_ctrl_regs #(
  parameter int N_CORES = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  hwpe_pkg::apb_req_t      apb_i,
  output hwpe_pkg::apb_rsp_t      apb_o,
  output hwpe_pkg::job_cfg_t      cfg_o,
  output logic                    start_o,
  input  logic                    done_i,
  input  logic [31:0]             result_i,
  output logic                    busy_o,
  output logic [N_CORES-1:0][1:0] evt_o
);

  import hwpe_pkg::*;

  // enough bits to index one core and never less than one
  localparam int CORE_W = (N_CORES > 1) ? $clog2(N_CORES) : 1;

  job_cfg_t                cfg_q;
  logic [7:0]              core_id_q;
  logic [CORE_W-1:0]       job_core_q;
  logic [CORE_W-1:0]       err_core;
  logic [31:0]             result_q;
  logic                    busy_q;
  logic                    start_q;
  logic [N_CORES-1:0][1:0] evt_q;

  logic apb_access;
  logic apb_write;
  logic trig_write;
  logic core_ok;
  logic trig_ok;
  logic trig_err;
  logic cfg_write;

  // the access cycle is the only cycle in which anything is decoded
  assign apb_access = apb_i.psel && apb_i.penable;
  assign apb_write  = apb_access && apb_i.pwrite;
  assign trig_write = apb_write && (apb_i.paddr == REG_TRIGGER);

  // a core id past the last core cannot receive its done event
  assign core_ok  = int'(core_id_q) < N_CORES;
  assign trig_ok  = trig_write && !busy_q && core_ok;
  assign trig_err = trig_write && !busy_q && !core_ok;
  // the error event goes to the core that the id wraps onto
  assign err_core = CORE_W'(int'(core_id_q) % N_CORES);

  // the job description is frozen for as long as the engine runs
  assign cfg_write = apb_write && !busy_q;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      cfg_q      <= '0;
      core_id_q  <= '0;
      job_core_q <= '0;
      result_q   <= '0;
      busy_q     <= 1'b0;
      start_q    <= 1'b0;
      evt_q      <= '0;
    end
    else
    begin
      start_q <= trig_ok;
      evt_q   <= '0;
      if (cfg_write)
      begin
        case (apb_i.paddr)
          REG_A_ADDR:  cfg_q.a_addr <= apb_i.pwdata;
          REG_B_ADDR:  cfg_q.b_addr <= apb_i.pwdata;
          REG_C_ADDR:  cfg_q.c_addr <= apb_i.pwdata;
          REG_LEN:     cfg_q.len    <= apb_i.pwdata[15:0];
          REG_MODE:    cfg_q.mode   <= mode_e'(apb_i.pwdata[0]);
          REG_CORE_ID: core_id_q    <= apb_i.pwdata[7:0];
          default:     ;
        endcase
      end
      // busy rises with start and drops in the cycle the event fires
      if (trig_ok)
      begin
        busy_q     <= 1'b1;
        job_core_q <= core_id_q[CORE_W-1:0];
      end
      if (done_i)
      begin
        busy_q                 <= 1'b0;
        result_q               <= result_i;
        evt_q[job_core_q][0] <= 1'b1;
      end
      if (trig_err)
        evt_q[err_core][1] <= 1'b1;
    end
  end

  // reads never wait because the data is muxed straight from the registers
  always_comb
  begin
    apb_o.pready  = 1'b1;
    apb_o.prdata  = '0;
    apb_o.pslverr = apb_write && busy_q && (apb_i.paddr != REG_TRIGGER);
    case (apb_i.paddr)
      REG_STATUS:  apb_o.prdata = {31'b0, busy_q};
      REG_A_ADDR:  apb_o.prdata = cfg_q.a_addr;
      REG_B_ADDR:  apb_o.prdata = cfg_q.b_addr;
      REG_C_ADDR:  apb_o.prdata = cfg_q.c_addr;
      REG_LEN:     apb_o.prdata = {16'b0, cfg_q.len};
      REG_MODE:    apb_o.prdata = {31'b0, cfg_q.mode};
      REG_CORE_ID: apb_o.prdata = {24'b0, core_id_q};
      REG_RESULT:  apb_o.prdata = result_q;
      default:     apb_o.prdata = '0;
    endcase
  end

  assign cfg_o   = cfg_q;
  assign start_o = start_q;
  assign busy_o  = busy_q;
  assign evt_o   = evt_q;

  // a start only reaches an idle engine and the job counts as running at once
  start_while_idle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    start_o |-> (busy_q && !done_i)
  );

  // every setup cycle is followed by an access cycle that completes at once
  access_completes: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (apb_i.psel && !apb_i.penable) |=> (apb_i.penable && apb_o.pready)
  );

endmodule

`default_nettype wire

// File: verilog/hwpe_clock_gate.sv
`timescale 1ns/1ps
`default_nettype none

module hwpe_clock_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic test_en_i,
  output logic clk_o
);

  logic en_latched;

  // the enable may only change while the clock is low
  // so a late enable cannot chop a high phase short
  always_latch
  begin
    if (!clk_i)
      en_latched = en_i | test_en_i;
  end

  // test mode forces the gate open so scan sees every edge
  assign clk_o = clk_i & en_latched;

endmodule

`default_nettype wire

// File: verilog/hwpe_pkg.sv
`default_nettype none

package hwpe_pkg;

  // memory side uses byte addresses on a one word wide port
  localparam int ADDR_W     = 32;
  // configuration side only needs to reach nine word registers
  localparam int REG_ADDR_W = 8;

  // register map as byte offsets, one word per register
  localparam logic [REG_ADDR_W-1:0] REG_TRIGGER = 8'h00;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS  = 8'h04;
  localparam logic [REG_ADDR_W-1:0] REG_A_ADDR  = 8'h08;
  localparam logic [REG_ADDR_W-1:0] REG_B_ADDR  = 8'h0C;
  localparam logic [REG_ADDR_W-1:0] REG_C_ADDR  = 8'h10;
  localparam logic [REG_ADDR_W-1:0] REG_LEN     = 8'h14;
  localparam logic [REG_ADDR_W-1:0] REG_MODE    = 8'h18;
  localparam logic [REG_ADDR_W-1:0] REG_CORE_ID = 8'h1C;
  localparam logic [REG_ADDR_W-1:0] REG_RESULT  = 8'h20;

  // per job choice of how an operand word is split
  typedef enum logic {
    MODE_W32 = 1'b0,
    MODE_H16 = 1'b1
  } mode_e;

  // two signed halves of a word, hi sits in bits 31:16
  typedef struct packed {
    logic signed [15:0] hi;
    logic signed [15:0] lo;
  } lanes_t;

  // the same memory word read as one value or as two lanes
  typedef union packed {
    logic signed [31:0] w32;
    lanes_t             h16;
  } operand_u;

  // everything the engine needs to run one job
  typedef struct packed {
    logic [ADDR_W-1:0] a_addr;
    logic [ADDR_W-1:0] b_addr;
    logic [ADDR_W-1:0] c_addr;
    logic [15:0]       len;
    mode_e             mode;
  } job_cfg_t;

  // wen high means a read, as on the cluster memory ports
  typedef struct packed {
    logic              req;
    logic              wen;
    logic [ADDR_W-1:0] add;
    logic [31:0]       wdata;
  } mem_req_t;

  typedef struct packed {
    logic        gnt;
    logic        r_valid;
    logic [31:0] r_data;
  } mem_rsp_t;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [REG_ADDR_W-1:0] paddr;
    logic [31:0]           pwdata;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire
